/* verilog/rv32_decode_macros.svh */
`ifndef RV32_DECODE_MACROS_SVH
`define RV32_DECODE_MACROS_SVH

// RV32I base opcodes
`define RV32_OP_LUI     7'b0110111
`define RV32_OP_AUIPC   7'b0010111
`define RV32_OP_JAL     7'b1101111
`define RV32_OP_JALR    7'b1100111
`define RV32_OP_BRANCH  7'b1100011
`define RV32_OP_LOAD    7'b0000011
`define RV32_OP_STORE   7'b0100011
`define RV32_OP_IMM     7'b0010011
`define RV32_OP_REG     7'b0110011
`define RV32_OP_SYSTEM  7'b1110011

// Immediate kind encodings
`define RV32_IMM_I      3'b000
`define RV32_IMM_B      3'b001
`define RV32_IMM_S      3'b010
`define RV32_IMM_U      3'b011
`define RV32_IMM_J      3'b100
`define RV32_IMM_SHAMT  3'b101
`define RV32_IMM_CSR    3'b110
`define RV32_IMM_NONE   3'b111

// Machine exception PC
`define RV32_CSR_MEPC   12'h341

// Exact MRET word is funct12 0x302 under SYSTEM with all other fields zero
`define RV32_MRET_WORD  32'b0011000_00010_00000_000_00000_1110011

`endif

/* verilog/rv32_pkg.sv */
`default_nettype none

`include "rv32_decode_macros.svh"

package rv32_pkg;

    typedef enum logic [2:0] {
        IMM_I     = `RV32_IMM_I,
        IMM_B     = `RV32_IMM_B,
        IMM_S     = `RV32_IMM_S,
        IMM_U     = `RV32_IMM_U,
        IMM_J     = `RV32_IMM_J,
        IMM_SHAMT = `RV32_IMM_SHAMT,
        IMM_CSR   = `RV32_IMM_CSR,
        IMM_NONE  = `RV32_IMM_NONE
    } imm_kind_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // Also the CSR format, with the CSR address in imm_11_0
    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word seen through every base format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } rv32_instr_t;

endpackage

`default_nettype wire

/* verilog/imm_extractor.sv */
`timescale 1ns/100ps
`default_nettype none

module imm_extractor (
    input  rv32_pkg::rv32_instr_t instr,
    input  rv32_pkg::imm_kind_t   imm_kind,
    output logic [31:0]           imm
);

    import rv32_pkg::*;

    always_comb begin
        case (imm_kind)
            IMM_I: begin
                imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
            IMM_S: begin
                imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            end
            // Branch offsets are in halfwords, so bit 0 is always zero
            IMM_B: begin
                imm = {{19{instr.b.imm_12}},
                       instr.b.imm_12,
                       instr.b.imm_11,
                       instr.b.imm_10_5,
                       instr.b.imm_4_1,
                       1'b0};
            end
            IMM_U: begin
                imm = {instr.u.imm_31_12, 12'd0};
            end
            IMM_J: begin
                imm = {{11{instr.j.imm_20}},
                       instr.j.imm_20,
                       instr.j.imm_19_12,
                       instr.j.imm_11,
                       instr.j.imm_10_1,
                       1'b0};
            end
            // Shift amount sits in the rs2 slot
            IMM_SHAMT: begin
                imm = {27'd0, instr.r.rs2};
            end
            // uimm for CSRRxI sits in the rs1 slot
            IMM_CSR: begin
                imm = {27'd0, instr.r.rs1};
            end
            default: begin
                imm = 32'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/id_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv32_decode_macros.svh"

module id_stage (
    input  rv32_pkg::rv32_instr_t ir,
    output logic [4:0]            rs1_addr,
    output logic [4:0]            rs2_addr,
    output logic [4:0]            rd,
    output logic [6:0]            opcode,
    output logic [2:0]            funct3,
    output logic [6:0]            funct7,
    output logic [11:0]           csr_addr,
    output rv32_pkg::imm_kind_t   imm_kind,
    output logic                  wr_reg_n,
    output logic                  wr_csr_n,
    output logic                  is_mret,
    output logic                  illegal
);

    import rv32_pkg::*;

    logic is_csr_op;

    // Common fields all live at the R-format positions
    assign opcode   = ir.r.opcode;
    assign rd       = ir.r.rd;
    assign funct3   = ir.r.funct3;
    assign rs1_addr = ir.r.rs1;
    assign rs2_addr = ir.r.rs2;
    assign funct7   = ir.r.funct7;

    assign is_mret = (ir == `RV32_MRET_WORD);

    // MRET reads mepc, so point the CSR address there for forwarding
    assign csr_addr = is_mret ? `RV32_CSR_MEPC : ir.i.imm_11_0;

    // CSRRW/S/C and their immediate forms; funct3 000 is ECALL/EBREAK/MRET
    assign is_csr_op = (opcode == `RV32_OP_SYSTEM) && (funct3 != 3'b000);

    always_comb begin
        case (opcode)
            `RV32_OP_LUI, `RV32_OP_AUIPC: imm_kind = IMM_U;
            `RV32_OP_JAL:                 imm_kind = IMM_J;
            `RV32_OP_JALR, `RV32_OP_LOAD: imm_kind = IMM_I;
            `RV32_OP_BRANCH:              imm_kind = IMM_B;
            `RV32_OP_STORE:               imm_kind = IMM_S;
            `RV32_OP_IMM: begin
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm_kind = IMM_SHAMT;
                end else begin
                    imm_kind = IMM_I;
                end
            end
            `RV32_OP_SYSTEM:              imm_kind = IMM_CSR;
            default:                      imm_kind = IMM_NONE;
        endcase
    end

    // Whitelist of opcodes that write rd, and never x0
    always_comb begin
        case (opcode)
            `RV32_OP_LUI, `RV32_OP_AUIPC, `RV32_OP_IMM, `RV32_OP_REG,
            `RV32_OP_LOAD, `RV32_OP_JAL, `RV32_OP_JALR: wr_reg_n = (rd == 5'd0);
            `RV32_OP_SYSTEM:                             wr_reg_n = !is_csr_op || (rd == 5'd0);
            default:                                     wr_reg_n = 1'b1;
        endcase
    end

    // CSRRS with rs1 x0 is the plain CSR read, no write
    assign wr_csr_n = !is_csr_op || ((funct3 == 3'b010) && (rs1_addr == 5'd0));

    always_comb begin
        case (opcode)
            `RV32_OP_LUI, `RV32_OP_AUIPC, `RV32_OP_JAL: illegal = 1'b0;
            `RV32_OP_JALR:   illegal = (funct3 != 3'b000);
            `RV32_OP_BRANCH: illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
            `RV32_OP_LOAD:   illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            `RV32_OP_STORE:  illegal = (funct3[2] == 1'b1) || (funct3 == 3'b011);
            `RV32_OP_IMM: begin
                if (funct3 == 3'b001) begin
                    illegal = (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    // SRLI or SRAI
                    illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end else begin
                    illegal = 1'b0;
                end
            end
            `RV32_OP_REG: begin
                if (funct3 == 3'b000 || funct3 == 3'b101) begin
                    // ADD/SUB and SRL/SRA
                    illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end else begin
                    illegal = (funct7 != 7'b0000000);
                end
            end
            `RV32_OP_SYSTEM: begin
                if (funct3 == 3'b000) begin
                    illegal = !is_mret;
                end else begin
                    illegal = (funct3 == 3'b100);
                end
            end
            default:         illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic        wb_we,
    input  logic [4:0]  wb_rd,
    input  logic [31:0] wb_data
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    // x0 reads zero; a write in the same cycle is seen immediately
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'd0;
        end else if (wb_we && (wb_rd == addr)) begin
            return wb_data;
        end else begin
            return regs[addr];
        end
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wb_we && (wb_rd != 5'd0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

`default_nettype wire

/* verilog/id_ex_latch.sv */
`timescale 1ns/100ps
`default_nettype none

module id_ex_latch (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic [4:0]  in_rd,
    input  logic [6:0]  in_opcode,
    input  logic [2:0]  in_funct3,
    input  logic [6:0]  in_funct7,
    input  logic [11:0] in_csr_addr,
    input  logic [31:0] in_imm,
    input  logic [31:0] in_rs1_data,
    input  logic [31:0] in_rs2_data,
    input  logic        in_wr_reg_n,
    input  logic        in_wr_csr_n,
    input  logic        in_is_mret,
    input  logic        in_illegal,
    output logic        ex_valid,
    output logic [4:0]  ex_rd,
    output logic [6:0]  ex_opcode,
    output logic [2:0]  ex_funct3,
    output logic [6:0]  ex_funct7,
    output logic [11:0] ex_csr_addr,
    output logic [31:0] ex_imm,
    output logic [31:0] ex_rs1_data,
    output logic [31:0] ex_rs2_data,
    output logic        ex_wr_reg_n,
    output logic        ex_wr_csr_n,
    output logic        ex_is_mret,
    output logic        ex_illegal
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid    <= 1'b0;
            ex_rd       <= 5'd0;
            ex_opcode   <= 7'd0;
            ex_funct3   <= 3'd0;
            ex_funct7   <= 7'd0;
            ex_csr_addr <= 12'd0;
            ex_imm      <= 32'd0;
            ex_rs1_data <= 32'd0;
            ex_rs2_data <= 32'd0;
            // Write enables are active low, so idle means high
            ex_wr_reg_n <= 1'b1;
            ex_wr_csr_n <= 1'b1;
            ex_is_mret  <= 1'b0;
            ex_illegal  <= 1'b0;
        end else begin
            ex_valid <= in_valid;
            // Fields hold across bubbles
            if (in_valid) begin
                ex_rd       <= in_rd;
                ex_opcode   <= in_opcode;
                ex_funct3   <= in_funct3;
                ex_funct7   <= in_funct7;
                ex_csr_addr <= in_csr_addr;
                ex_imm      <= in_imm;
                ex_rs1_data <= in_rs1_data;
                ex_rs2_data <= in_rs2_data;
                ex_wr_reg_n <= in_wr_reg_n;
                ex_wr_csr_n <= in_wr_csr_n;
                ex_is_mret  <= in_is_mret;
                ex_illegal  <= in_illegal;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/decode_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_unit (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] ir,
    input  logic        ir_valid,
    input  logic        wb_we,
    input  logic [4:0]  wb_rd,
    input  logic [31:0] wb_data,
    output logic        ex_valid,
    output logic [4:0]  ex_rd,
    output logic [6:0]  ex_opcode,
    output logic [2:0]  ex_funct3,
    output logic [6:0]  ex_funct7,
    output logic [11:0] ex_csr_addr,
    output logic [31:0] ex_imm,
    output logic [31:0] ex_rs1_data,
    output logic [31:0] ex_rs2_data,
    output logic        ex_wr_reg_n,
    output logic        ex_wr_csr_n,
    output logic        ex_is_mret,
    output logic        ex_illegal
);

    import rv32_pkg::*;

    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [4:0]  rd;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] csr_addr;
    imm_kind_t   imm_kind;
    logic [31:0] imm;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        wr_reg_n;
    logic        wr_csr_n;
    logic        is_mret;
    logic        illegal;

    id_stage id_stage_i (
        .ir       (ir),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd       (rd),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7   (funct7),
        .csr_addr (csr_addr),
        .imm_kind (imm_kind),
        .wr_reg_n (wr_reg_n),
        .wr_csr_n (wr_csr_n),
        .is_mret  (is_mret),
        .illegal  (illegal)
    );

    imm_extractor imm_extractor_i (
        .instr    (ir),
        .imm_kind (imm_kind),
        .imm      (imm)
    );

    // Operands are read in the decode cycle
    reg_file reg_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    id_ex_latch id_ex_latch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (ir_valid),
        .in_rd       (rd),
        .in_opcode   (opcode),
        .in_funct3   (funct3),
        .in_funct7   (funct7),
        .in_csr_addr (csr_addr),
        .in_imm      (imm),
        .in_rs1_data (rs1_data),
        .in_rs2_data (rs2_data),
        .in_wr_reg_n (wr_reg_n),
        .in_wr_csr_n (wr_csr_n),
        .in_is_mret  (is_mret),
        .in_illegal  (illegal),
        .ex_valid    (ex_valid),
        .ex_rd       (ex_rd),
        .ex_opcode   (ex_opcode),
        .ex_funct3   (ex_funct3),
        .ex_funct7   (ex_funct7),
        .ex_csr_addr (ex_csr_addr),
        .ex_imm      (ex_imm),
        .ex_rs1_data (ex_rs1_data),
        .ex_rs2_data (ex_rs2_data),
        .ex_wr_reg_n (ex_wr_reg_n),
        .ex_wr_csr_n (ex_wr_csr_n),
        .ex_is_mret  (ex_is_mret),
        .ex_illegal  (ex_illegal)
    );

endmodule

`default_nettype wire

/* verif/decode_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ir_valid,
    input  logic        ex_valid,
    input  logic [4:0]  ex_rd,
    input  logic [6:0]  ex_opcode,
    input  logic [2:0]  ex_funct3,
    input  logic [6:0]  ex_funct7,
    input  logic [11:0] ex_csr_addr,
    input  logic [31:0] ex_imm,
    input  logic [31:0] ex_rs1_data,
    input  logic [31:0] ex_rs2_data,
    input  logic [3:0]  ex_flags,
    input  int          exp_id,
    input  logic [4:0]  exp_rd,
    input  logic [6:0]  exp_opcode,
    input  logic [2:0]  exp_funct3,
    input  logic [6:0]  exp_funct7,
    input  logic [11:0] exp_csr,
    input  logic [31:0] exp_imm,
    input  logic [31:0] exp_rs1,
    input  logic [31:0] exp_rs2,
    input  logic [3:0]  exp_flags,
    output int          test_count,
    output int          error_count
);

    // Expected values line up with the ex_ outputs one clock later
    int          id_q;
    logic        valid_q;
    logic [4:0]  rd_q;
    logic [6:0]  opcode_q;
    logic [2:0]  funct3_q;
    logic [6:0]  funct7_q;
    logic [11:0] csr_q;
    logic [31:0] imm_q;
    logic [31:0] rs1_q;
    logic [31:0] rs2_q;
    logic [3:0]  flags_q;
    int          test_errors;

    initial begin
        test_count = 0;
        error_count = 0;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= ir_valid;
        end
    end

    always @(posedge clk) begin
        id_q     <= exp_id;
        rd_q     <= exp_rd;
        opcode_q <= exp_opcode;
        funct3_q <= exp_funct3;
        funct7_q <= exp_funct7;
        csr_q    <= exp_csr;
        imm_q    <= exp_imm;
        rs1_q    <= exp_rs1;
        rs2_q    <= exp_rs2;
        flags_q  <= exp_flags;
    end

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: test %0d field %s got %h expected %h",
                     $time, id_q, name, got, exp);
            test_errors++;
        end
    endtask

    // Compare mid-cycle, well away from the rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (ex_valid !== valid_q) begin
                $display("FAILED at %0t: ex_valid is %b, expected %b",
                         $time, ex_valid, valid_q);
                error_count++;
            end
            if (ex_valid === 1'b1) begin
                test_errors = 0;
                check_field("rd", 32'(ex_rd), 32'(rd_q));
                check_field("opcode", 32'(ex_opcode), 32'(opcode_q));
                check_field("funct3", 32'(ex_funct3), 32'(funct3_q));
                check_field("funct7", 32'(ex_funct7), 32'(funct7_q));
                check_field("csr_addr", 32'(ex_csr_addr), 32'(csr_q));
                check_field("imm", ex_imm, imm_q);
                check_field("rs1_data", ex_rs1_data, rs1_q);
                check_field("rs2_data", ex_rs2_data, rs2_q);
                check_field("wr_reg_n", 32'(ex_flags[3]), 32'(flags_q[3]));
                check_field("wr_csr_n", 32'(ex_flags[2]), 32'(flags_q[2]));
                check_field("is_mret", 32'(ex_flags[1]), 32'(flags_q[1]));
                check_field("illegal", 32'(ex_flags[0]), 32'(flags_q[0]));
                if (test_errors == 0) begin
                    $display("test %0d ok", id_q);
                end else begin
                    $display("test %0d had %0d mismatches", id_q, test_errors);
                end
                error_count += test_errors;
                test_count++;
            end
        end
    end

endmodule

`default_nettype wire

/* verif/decode_unit_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_unit_asserts (
    input logic       clk,
    input logic       rst_n,
    input logic       in_valid,
    input logic       ex_valid,
    input logic [4:0] ex_rd,
    input logic       ex_wr_reg_n
);

    valid_low_in_reset: assert property (@(posedge clk) !rst_n |-> !ex_valid)
        else $error("ex_valid high during reset");

    valid_follows_input: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (ex_valid == $past(in_valid)))
        else $error("ex_valid does not follow in_valid by one cycle");

    // x0 is never a write target
    no_write_to_x0: assert property (@(posedge clk) disable iff (!rst_n)
        (ex_rd == 5'd0) |-> ex_wr_reg_n)
        else $error("register write enabled with rd zero");

endmodule

bind id_ex_latch decode_unit_asserts decode_unit_asserts_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .ex_valid    (ex_valid),
    .ex_rd       (ex_rd),
    .ex_wr_reg_n (ex_wr_reg_n)
);

`default_nettype wire

/* verif/decode_unit_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv32_decode_macros.svh"

module decode_unit_tb;

    typedef struct {
        logic [31:0] word;
        logic        wb_we;
        logic [4:0]  wb_rd;
        logic [31:0] wb_data;
        logic [31:0] imm;
        logic [3:0]  flags;
    } row_t;

    logic clk, rst_n, ir_valid, wb_we;
    logic [31:0] ir, wb_data;
    logic [4:0]  wb_rd;
    logic ex_valid, ex_wr_reg_n, ex_wr_csr_n, ex_is_mret, ex_illegal;
    logic [4:0]  ex_rd;
    logic [6:0]  ex_opcode, ex_funct7;
    logic [2:0]  ex_funct3;
    logic [11:0] ex_csr_addr;
    logic [31:0] ex_imm, ex_rs1_data, ex_rs2_data;
    int          exp_id, test_count, error_count;
    logic [4:0]  exp_rd;
    logic [6:0]  exp_opcode, exp_funct7;
    logic [2:0]  exp_funct3;
    logic [11:0] exp_csr;
    logic [31:0] exp_imm, exp_rs1, exp_rs2;
    logic [3:0]  exp_flags;
    logic [31:0] shadow [0:31];
    row_t        rows [$];
    logic        table_ready;

    always #20 clk = ~clk;

    decode_unit decode_unit_i (
        .clk(clk), .rst_n(rst_n), .ir(ir), .ir_valid(ir_valid),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
        .ex_valid(ex_valid), .ex_rd(ex_rd), .ex_opcode(ex_opcode),
        .ex_funct3(ex_funct3), .ex_funct7(ex_funct7), .ex_csr_addr(ex_csr_addr),
        .ex_imm(ex_imm), .ex_rs1_data(ex_rs1_data), .ex_rs2_data(ex_rs2_data),
        .ex_wr_reg_n(ex_wr_reg_n), .ex_wr_csr_n(ex_wr_csr_n),
        .ex_is_mret(ex_is_mret), .ex_illegal(ex_illegal)
    );

    decode_checker decode_checker_i (
        .clk(clk), .rst_n(rst_n), .ir_valid(ir_valid), .ex_valid(ex_valid),
        .ex_rd(ex_rd), .ex_opcode(ex_opcode), .ex_funct3(ex_funct3),
        .ex_funct7(ex_funct7), .ex_csr_addr(ex_csr_addr), .ex_imm(ex_imm),
        .ex_rs1_data(ex_rs1_data), .ex_rs2_data(ex_rs2_data),
        .ex_flags({ex_wr_reg_n, ex_wr_csr_n, ex_is_mret, ex_illegal}),
        .exp_id(exp_id), .exp_rd(exp_rd), .exp_opcode(exp_opcode),
        .exp_funct3(exp_funct3), .exp_funct7(exp_funct7), .exp_csr(exp_csr),
        .exp_imm(exp_imm), .exp_rs1(exp_rs1), .exp_rs2(exp_rs2),
        .exp_flags(exp_flags), .test_count(test_count), .error_count(error_count)
    );

    // Instruction encoders, one per base format
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
        input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV32_OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV32_OP_JAL};
    endfunction

    task automatic add_row(input logic [31:0] word, input logic we, input logic [4:0] rd,
        input logic [31:0] data, input logic [31:0] imm, input logic [3:0] flags);
        row_t r;
        r.word = word;
        r.wb_we = we;
        r.wb_rd = rd;
        r.wb_data = data;
        r.imm = imm;
        r.flags = flags;
        rows.push_back(r);
    endtask

    // Operand as seen in the decode cycle, with the same-cycle write bypassed
    function automatic logic [31:0] operand(input logic [4:0] addr, input row_t r);
        if (addr == 5'd0) begin
            return 32'd0;
        end
        if (r.wb_we && r.wb_rd == addr) begin
            return r.wb_data;
        end
        return shadow[addr];
    endfunction

    task automatic build_table();
        // Flag bits from the top are wr_reg_n, wr_csr_n, is_mret and illegal
        add_row(enc_r(7'h00, 2, 1, 0, 3, `RV32_OP_REG), 0, 0, 0, 32'h0, 4'b0100);
        add_row(enc_r(7'h20, 7, 6, 0, 5, `RV32_OP_REG), 0, 0, 0, 32'h0, 4'b0100);
        add_row(enc_r(7'h20, 2, 1, 1, 4, `RV32_OP_REG), 0, 0, 0, 32'h0, 4'b0101);
        add_row(enc_i(12'hffb, 9, 0, 8, `RV32_OP_IMM), 0, 0, 0, 32'hfffffffb, 4'b0100);
        add_row(enc_i(12'h07f, 1, 0, 0, `RV32_OP_IMM), 0, 0, 0, 32'h7f, 4'b1100);
        add_row(enc_i({7'h00, 5'd13}, 11, 1, 10, `RV32_OP_IMM), 0, 0, 0, 32'd13, 4'b0100);
        add_row(enc_i({7'h20, 5'd31}, 13, 5, 12, `RV32_OP_IMM), 0, 0, 0, 32'd31, 4'b0100);
        add_row(enc_i({7'h20, 5'd3}, 1, 1, 2, `RV32_OP_IMM), 0, 0, 0, 32'd3, 4'b0101);
        add_row(enc_i(12'h800, 15, 2, 14, `RV32_OP_LOAD), 0, 0, 0, 32'hfffff800, 4'b0100);
        add_row(enc_i(12'h010, 1, 3, 2, `RV32_OP_LOAD), 0, 0, 0, 32'h10, 4'b0101);
        add_row(enc_s(12'hffc, 16, 17, 2, `RV32_OP_STORE), 0, 0, 0, 32'hfffffffc, 4'b1100);
        add_row(enc_s(12'h004, 1, 2, 4, `RV32_OP_STORE), 0, 0, 0, 32'h4, 4'b1101);
        add_row(enc_b(13'h1ff8, 2, 1, 0), 0, 0, 0, 32'hfffffff8, 4'b1100);
        add_row(enc_b(13'h0800, 3, 4, 2), 0, 0, 0, 32'h800, 4'b1101);
        add_row({20'habcde, 5'd20, `RV32_OP_LUI}, 0, 0, 0, 32'habcde000, 4'b0100);
        add_row({20'h00001, 5'd21, `RV32_OP_AUIPC}, 0, 0, 0, 32'h1000, 4'b0100);
        add_row(enc_j(21'h1ffffe, 1), 0, 0, 0, 32'hfffffffe, 4'b0100);
        add_row(enc_j(21'h000800, 0), 0, 0, 0, 32'h800, 4'b1100);
        add_row(enc_i(12'h004, 1, 1, 5, `RV32_OP_JALR), 0, 0, 0, 32'h4, 4'b0101);
        add_row(enc_i(12'h340, 23, 1, 22, `RV32_OP_SYSTEM), 0, 0, 0, 32'd23, 4'b0000);
        add_row(enc_i(12'h300, 0, 2, 24, `RV32_OP_SYSTEM), 0, 0, 0, 32'h0, 4'b0100);
        add_row(enc_i(12'h305, 5, 5, 0, `RV32_OP_SYSTEM), 0, 0, 0, 32'h5, 4'b1000);
        add_row(32'h00000073, 0, 0, 0, 32'h0, 4'b1101);
        add_row(enc_i(12'h300, 1, 4, 2, `RV32_OP_SYSTEM), 0, 0, 0, 32'h1, 4'b0001);
        add_row(`RV32_MRET_WORD, 0, 0, 0, 32'h0, 4'b1110);
        add_row(enc_i(12'h000, 1, 0, 2, 7'b0001111), 0, 0, 0, 32'h0, 4'b1101);
        // Write to x0 must not show up, write to x9 is bypassed
        add_row(enc_r(7'h00, 0, 0, 0, 1, `RV32_OP_REG), 1, 0, 32'hdeadbeef, 32'h0, 4'b0100);
        add_row(enc_r(7'h00, 9, 9, 0, 2, `RV32_OP_REG), 1, 9, 32'h12345678, 32'h0, 4'b0100);
    endtask

    initial begin
        table_ready = 1'b0;
        wait (table_ready);
        #((rows.size() + 64) * 40);
        $display("Timeout: the DUT did not finish all tests in time");
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h7eb9));
        clk = 1'b0;
        rst_n = 1'b0;
        ir = 32'd0;
        ir_valid = 1'b0;
        wb_we = 1'b0;
        wb_rd = 5'd0;
        wb_data = 32'd0;
        exp_id = 0;
        {exp_rd, exp_opcode, exp_funct3, exp_funct7, exp_csr} = '0;
        {exp_imm, exp_rs1, exp_rs2, exp_flags} = '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = 32'd0;
        end
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Load every register with random data, x0 included
        for (int r = 0; r < 32; r++) begin
            @(negedge clk);
            wb_we = 1'b1;
            wb_rd = 5'(r);
            wb_data = $urandom;
            if (r != 0) begin
                shadow[r] = wb_data;
            end
        end
        foreach (rows[n]) begin
            @(negedge clk);
            ir = rows[n].word;
            ir_valid = 1'b1;
            wb_we = rows[n].wb_we;
            wb_rd = rows[n].wb_rd;
            wb_data = rows[n].wb_data;
            exp_id = n;
            exp_rd = rows[n].word[11:7];
            exp_opcode = rows[n].word[6:0];
            exp_funct3 = rows[n].word[14:12];
            exp_funct7 = rows[n].word[31:25];
            exp_csr = rows[n].flags[1] ? `RV32_CSR_MEPC : rows[n].word[31:20];
            exp_imm = rows[n].imm;
            exp_rs1 = operand(rows[n].word[19:15], rows[n]);
            exp_rs2 = operand(rows[n].word[24:20], rows[n]);
            exp_flags = rows[n].flags;
            if (rows[n].wb_we && rows[n].wb_rd != 5'd0) begin
                shadow[rows[n].wb_rd] = rows[n].wb_data;
            end
        end
        @(negedge clk);
        ir_valid = 1'b0;
        wb_we = 1'b0;
        wait (test_count == rows.size());
        repeat (2) @(negedge clk);
        $display("tests run %0d, errors %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verilog
verilog/rv32_pkg.sv
verilog/imm_extractor.sv
verilog/id_stage.sv
verilog/reg_file.sv
verilog/id_ex_latch.sv
verilog/decode_unit.sv
verif/decode_checker.sv
verif/decode_unit_asserts.sv
verif/decode_unit_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the decode unit simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
    --top-module decode_unit_tb -o decode_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/decode_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Verification passed"; then
    exit 0
fi
exit 1
